/* background/background_controller.sv */
// map and tile strides are fixed; a line must finish rendering before the next h_tick
`include "gfx_defines.svh"

module background_controller (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  video_pkg::reg_addr_t    reg_addr,
	input  logic [15:0]             reg_data,
	input  logic                    reg_wr,
	input  logic                    h_tick,
	input  video_pkg::pix_coord_t   pixel_x,
	input  video_pkg::pix_coord_t   pixel_y,
	output video_pkg::color_index_t color,
	output logic                    rd_valid,
	output mem_pkg::mem_addr_t      rd_addr,
	input  mem_pkg::mem_word_t      rd_data,
	input  logic                    rd_ready
);

	localparam video_pkg::pix_coord_t render_start = video_pkg::pix_coord_t'(`GFX_H_START);
	localparam video_pkg::pix_coord_t render_end =
		video_pkg::pix_coord_t'(`GFX_H_START + `GFX_ACTIVE_W);
	localparam mem_addr_words_per_tile = `GFX_TILE_SIZE * `GFX_TILE_SIZE / 4;

	// host registers
	logic        bg_enable;
	logic [3:0]  pal_hi;
	logic [15:0] scroll_x;
	logic [15:0] scroll_y;
	mem_pkg::mem_addr_t map_base;
	mem_pkg::mem_addr_t tile_base;

	video_pkg::render_state_t state;
	video_pkg::pix_coord_t cur_x;
	logic [15:0] img_x;
	logic [15:0] img_y;
	mem_pkg::tile_idx_t cur_tile;
	mem_pkg::mem_word_t tile_word;

	// buffer selection and display side clear
	logic render_buf;
	logic shown_q;
	video_pkg::pix_coord_t clear_x;

	logic [15:0]            map_byte_off;
	mem_pkg::mem_addr_t     map_word_addr;
	mem_pkg::mem_addr_t     tile_word_addr;
	logic [4:0]             skip_len;
	logic                   is_blit;
	video_pkg::pix_nibble_t blit_nib;
	video_pkg::pix_nibble_t buf_rd_data [2];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			bg_enable <= 1'b0;
			pal_hi    <= '0;
			scroll_x  <= '0;
			scroll_y  <= '0;
			map_base  <= '0;
			tile_base <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				// bit 0 enable, bits 7:4 palette high nibble
				`GFX_REG_CTRL: begin
					bg_enable <= reg_data[0];
					pal_hi    <= reg_data[7:4];
				end
				`GFX_REG_SCROLL_X: scroll_x <= reg_data;
				`GFX_REG_SCROLL_Y: scroll_y <= reg_data;
				`GFX_REG_MAP_BASE: map_base <= reg_data;
				`GFX_REG_TILE_BASE: tile_base <= reg_data;
				default: ;
			endcase
		end
	end

	// map byte for the tile under img_x, even byte is the low half
	assign map_byte_off = {4'd0, img_y[15:4]} * 16'(`GFX_MAP_STRIDE) + {4'd0, img_x[15:4]};
	assign map_word_addr = map_base + {1'b0, map_byte_off[15:1]};

	assign tile_word_addr = tile_base +
		mem_pkg::mem_addr_t'(cur_tile) * mem_pkg::mem_addr_t'(mem_addr_words_per_tile) +
		mem_pkg::mem_addr_t'(img_y[3:0]) * mem_pkg::mem_addr_t'(`GFX_TILE_SIZE / 4) +
		mem_pkg::mem_addr_t'(img_x[3:2]);

	// pixels left to the tile edge
	assign skip_len = 5'(`GFX_TILE_SIZE) - {1'b0, img_x[3:0]};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state      <= video_pkg::rs_idle;
			rd_valid   <= 1'b0;
			render_buf <= 1'b0;
			shown_q    <= 1'b1;
		end else begin
			shown_q <= ~render_buf;
			if (h_tick) begin
				// swap every line so both buffers keep being cleared
				render_buf <= ~render_buf;
				rd_valid   <= 1'b0;
				img_y      <= scroll_y + 16'(pixel_y) + 16'd1 - 16'(`GFX_V_START);
				state      <= bg_enable ? video_pkg::rs_begin : video_pkg::rs_idle;
			end else begin
				case (state)
					video_pkg::rs_idle: ;
					video_pkg::rs_begin: begin
						cur_x <= render_start;
						img_x <= scroll_x;
						state <= video_pkg::rs_load_map;
					end
					video_pkg::rs_load_map: begin
						rd_addr  <= map_word_addr;
						rd_valid <= 1'b1;
						state    <= video_pkg::rs_wait_map;
					end
					video_pkg::rs_wait_map: begin
						if (rd_ready) begin
							rd_valid <= 1'b0;
							cur_tile <= img_x[4] ? rd_data[15:8] : rd_data[7:0];
							state    <= video_pkg::rs_load_tile;
						end
					end
					video_pkg::rs_load_tile: begin
						if (cur_tile == `GFX_TRANSPARENT_TILE) begin
							// leave the cleared zeros in place
							cur_x <= cur_x + video_pkg::pix_coord_t'(skip_len);
							img_x <= img_x + 16'(skip_len);
							state <= video_pkg::rs_finish;
						end else begin
							rd_addr  <= tile_word_addr;
							rd_valid <= 1'b1;
							state    <= video_pkg::rs_wait_tile;
						end
					end
					video_pkg::rs_wait_tile: begin
						if (rd_ready) begin
							rd_valid  <= 1'b0;
							tile_word <= rd_data;
							// enter at the first wanted nibble of the word
							case (img_x[1:0])
								2'd0: state <= video_pkg::rs_blit0;
								2'd1: state <= video_pkg::rs_blit1;
								2'd2: state <= video_pkg::rs_blit2;
								default: state <= video_pkg::rs_blit3;
							endcase
						end
					end
					video_pkg::rs_blit0,
					video_pkg::rs_blit1,
					video_pkg::rs_blit2: begin
						cur_x <= cur_x + 1'b1;
						img_x <= img_x + 16'd1;
						state <= video_pkg::render_state_t'(state + 4'd1);
					end
					video_pkg::rs_blit3: begin
						cur_x <= cur_x + 1'b1;
						img_x <= img_x + 16'd1;
						if (img_x[3:0] == 4'(`GFX_TILE_SIZE - 1) || cur_x + 1'b1 >= render_end) begin
							state <= video_pkg::rs_finish;
						end else begin
							state <= video_pkg::rs_load_tile;
						end
					end
					video_pkg::rs_finish: begin
						state <= (cur_x >= render_end) ? video_pkg::rs_idle
							: video_pkg::rs_load_map;
					end
					default: state <= video_pkg::rs_idle;
				endcase
			end
		end
	end

	// location read last cycle gets cleared now
	always_ff @(posedge CLK) begin
		clear_x <= pixel_x;
	end

	assign is_blit = (state == video_pkg::rs_blit0) || (state == video_pkg::rs_blit1) ||
		(state == video_pkg::rs_blit2) || (state == video_pkg::rs_blit3);

	always_comb begin
		case (state)
			video_pkg::rs_blit0: blit_nib = tile_word[3:0];
			video_pkg::rs_blit1: blit_nib = tile_word[7:4];
			video_pkg::rs_blit2: blit_nib = tile_word[11:8];
			video_pkg::rs_blit3: blit_nib = tile_word[15:12];
			default: blit_nib = '0;
		endcase
	end

	for (genvar b = 0; b < 2; b++) begin : g_line
		logic render_hit;
		logic wr;
		video_pkg::pix_coord_t wr_addr;
		video_pkg::pix_nibble_t wr_data;

		// renderer wins over the clear when both hit one buffer
		assign render_hit = is_blit && (render_buf == 1'(b));
		assign wr = render_hit || (shown_q == 1'(b));
		assign wr_addr = render_hit ? cur_x : clear_x;
		assign wr_data = render_hit ? blit_nib : '0;

		scanline_buffer u_line (
			.CLK     (CLK),
			.rd_addr (pixel_x),
			.rd_data (buf_rd_data[b]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.wr      (wr)
		);
	end

	assign color = bg_enable ? {pal_hi, buf_rd_data[shown_q]} : '0;

endmodule

/* background/scanline_buffer.sv */
// one line of 4-bit pixels, 1024 deep, read data one cycle after the address, no reset
module scanline_buffer (
	input  logic                   CLK,
	input  video_pkg::pix_coord_t  rd_addr,
	output video_pkg::pix_nibble_t rd_data,
	input  video_pkg::pix_coord_t  wr_addr,
	input  video_pkg::pix_nibble_t wr_data,
	input  logic                   wr
);

	video_pkg::pix_nibble_t mem [0:1023];

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read port
	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* common/gfx_defines.svh */
// small simulation timings only; the active window must fit inside one line and one frame
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// raster timing
`define GFX_LINE_TOTAL 256
`define GFX_FRAME_LINES 40
`define GFX_H_START 16
`define GFX_ACTIVE_W 64
`define GFX_V_START 2
`define GFX_ACTIVE_H 32

// tile geometry, 4 bits per pixel
`define GFX_TILE_SIZE 16
`define GFX_MAP_STRIDE 128
`define GFX_TRANSPARENT_TILE 8'hff

// tile memory words actually decoded
`define GFX_MEM_DEPTH_BITS 12

// host register map
`define GFX_REG_CTRL 4'd0
`define GFX_REG_SCROLL_X 4'd1
`define GFX_REG_SCROLL_Y 4'd2
`define GFX_REG_MAP_BASE 4'd3
`define GFX_REG_TILE_BASE 4'd4

`endif

/* common/mem_pkg.sv */
// tile memory types; addresses are 16-bit word addresses, data words hold 4 pixels
package mem_pkg;

	// word address into tile memory
	typedef logic [15:0] mem_addr_t;

	// one memory word, 4 nibbles low first
	typedef logic [15:0] mem_word_t;

	// tile number as held in the map
	typedef logic [7:0] tile_idx_t;

	// who currently owns the memory
	typedef enum logic [1:0] {
		arb_none,
		arb_renderer,
		arb_host
	} arb_owner_t;

endpackage

/* common/video_pkg.sv */
// raster side types; coordinates are 10 bits, so a line or frame is at most 1024 long
package video_pkg;

	// pixel or line position
	typedef logic [9:0] pix_coord_t;

	// one pixel as stored in a scanline buffer
	typedef logic [3:0] pix_nibble_t;

	// palette high nibble followed by the pixel nibble
	typedef logic [7:0] color_index_t;

	typedef logic [3:0] reg_addr_t;

	// background renderer states
	typedef enum logic [3:0] {
		rs_idle,
		rs_begin,
		rs_load_map,
		rs_wait_map,
		rs_load_tile,
		rs_wait_tile,
		rs_blit0,
		rs_blit1,
		rs_blit2,
		rs_blit3,
		rs_finish
	} render_state_t;

endpackage

/* project.f */
+incdir+common
common/video_pkg.sv
common/mem_pkg.sv
rtl/video_timing.sv
background/scanline_buffer.sv
background/background_controller.sv
rtl/mem_arbiter.sv
rtl/tile_memory.sv
rtl/gfx_top.sv
sim/gfx_chk.sv
sim/gfx_tb.sv

/* rtl/gfx_top.sv */
// outputs lag the raster counters by one cycle; no host read path to tile memory
module gfx_top (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  video_pkg::reg_addr_t    reg_addr,
	input  logic [15:0]             reg_data,
	input  logic                    reg_wr,
	input  logic                    host_valid,
	input  mem_pkg::mem_addr_t      host_addr,
	input  mem_pkg::mem_word_t      host_data,
	output logic                    host_ready,
	output video_pkg::pix_coord_t   out_x,
	output video_pkg::pix_coord_t   out_y,
	output video_pkg::color_index_t out_color
);

	video_pkg::pix_coord_t   pixel_x;
	video_pkg::pix_coord_t   pixel_y;
	logic                    h_tick;
	logic                    active;
	logic                    active_q;
	video_pkg::color_index_t bg_color;

	logic               rd_valid;
	mem_pkg::mem_addr_t rd_addr;
	mem_pkg::mem_word_t rd_data;
	logic               rd_ready;

	logic               mem_en;
	logic               mem_we;
	mem_pkg::mem_addr_t mem_addr;
	mem_pkg::mem_word_t mem_wdata;
	mem_pkg::mem_word_t mem_rdata;

	video_timing u_timing (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.pixel_x (pixel_x),
		.pixel_y (pixel_y),
		.h_tick  (h_tick),
		.v_tick  (),
		.active  (active)
	);

	background_controller u_bg (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.reg_addr (reg_addr),
		.reg_data (reg_data),
		.reg_wr   (reg_wr),
		.h_tick   (h_tick),
		.pixel_x  (pixel_x),
		.pixel_y  (pixel_y),
		.color    (bg_color),
		.rd_valid (rd_valid),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.rd_ready (rd_ready)
	);

	mem_arbiter u_arb (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.rd_valid   (rd_valid),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.rd_ready   (rd_ready),
		.host_valid (host_valid),
		.host_addr  (host_addr),
		.host_data  (host_data),
		.host_ready (host_ready),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata)
	);

	tile_memory u_mem (
		.CLK   (CLK),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

	// match the one cycle scanline read latency
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			active_q <= 1'b0;
		end else begin
			active_q <= active;
		end
	end

	always_ff @(posedge CLK) begin
		out_x <= pixel_x;
		out_y <= pixel_y;
	end

	assign out_color = active_q ? bg_color : '0;

endmodule

/* rtl/mem_arbiter.sv */
// renderer always wins; a host write waits for a cycle with no renderer request
module mem_arbiter (
	input  logic               CLK,
	input  logic               RSTb,
	input  logic               rd_valid,
	input  mem_pkg::mem_addr_t rd_addr,
	output mem_pkg::mem_word_t rd_data,
	output logic               rd_ready,
	input  logic               host_valid,
	input  mem_pkg::mem_addr_t host_addr,
	input  mem_pkg::mem_word_t host_data,
	output logic               host_ready,
	output logic               mem_en,
	output logic               mem_we,
	output mem_pkg::mem_addr_t mem_addr,
	output mem_pkg::mem_word_t mem_wdata,
	input  mem_pkg::mem_word_t mem_rdata
);

	mem_pkg::arb_owner_t owner;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			owner      <= mem_pkg::arb_none;
			mem_en     <= 1'b0;
			mem_we     <= 1'b0;
			rd_ready   <= 1'b0;
			host_ready <= 1'b0;
		end else begin
			case (owner)
				mem_pkg::arb_none: begin
					if (rd_valid) begin
						owner    <= mem_pkg::arb_renderer;
						mem_en   <= 1'b1;
						mem_we   <= 1'b0;
						mem_addr <= rd_addr;
					end else if (host_valid) begin
						owner     <= mem_pkg::arb_host;
						mem_en    <= 1'b1;
						mem_we    <= 1'b1;
						mem_addr  <= host_addr;
						mem_wdata <= host_data;
					end
				end
				mem_pkg::arb_renderer: begin
					// grant held through the cycle the data comes back
					if (mem_en) begin
						mem_en   <= 1'b0;
						rd_ready <= 1'b1;
					end else begin
						rd_ready <= 1'b0;
						owner    <= mem_pkg::arb_none;
					end
				end
				mem_pkg::arb_host: begin
					if (mem_en) begin
						mem_en     <= 1'b0;
						mem_we     <= 1'b0;
						host_ready <= 1'b1;
					end else begin
						host_ready <= 1'b0;
						owner      <= mem_pkg::arb_none;
					end
				end
				default: owner <= mem_pkg::arb_none;
			endcase
		end
	end

	// memory output is valid in the rd_ready cycle
	assign rd_data = mem_rdata;

endmodule

/* rtl/tile_memory.sv */
// upper address bits above the decoded depth are ignored, so addresses alias
`include "gfx_defines.svh"

module tile_memory (
	input  logic               CLK,
	input  logic               en,
	input  logic               we,
	input  mem_pkg::mem_addr_t addr,
	input  mem_pkg::mem_word_t wdata,
	output mem_pkg::mem_word_t rdata
);

	mem_pkg::mem_word_t mem [0:(1 << `GFX_MEM_DEPTH_BITS) - 1];

	logic [`GFX_MEM_DEPTH_BITS-1:0] word_sel;

	assign word_sel = addr[`GFX_MEM_DEPTH_BITS-1:0];

	// single port, read data one cycle after en
	always_ff @(posedge CLK) begin
		if (en) begin
			if (we) begin
				mem[word_sel] <= wdata;
			end else begin
				rdata <= mem[word_sel];
			end
		end
	end

endmodule

/* rtl/video_timing.sv */
// ticks are registered, so h_tick and v_tick stay low for the first line after reset
`include "gfx_defines.svh"

module video_timing (
	input  logic                  CLK,
	input  logic                  RSTb,
	output video_pkg::pix_coord_t pixel_x,
	output video_pkg::pix_coord_t pixel_y,
	output logic                  h_tick,
	output logic                  v_tick,
	output logic                  active
);

	localparam video_pkg::pix_coord_t x_last = video_pkg::pix_coord_t'(`GFX_LINE_TOTAL - 1);
	localparam video_pkg::pix_coord_t y_last = video_pkg::pix_coord_t'(`GFX_FRAME_LINES - 1);
	localparam video_pkg::pix_coord_t h_first = video_pkg::pix_coord_t'(`GFX_H_START);
	localparam video_pkg::pix_coord_t h_end =
		video_pkg::pix_coord_t'(`GFX_H_START + `GFX_ACTIVE_W);
	localparam video_pkg::pix_coord_t v_first = video_pkg::pix_coord_t'(`GFX_V_START);
	localparam video_pkg::pix_coord_t v_end =
		video_pkg::pix_coord_t'(`GFX_V_START + `GFX_ACTIVE_H);

	logic x_wrap;
	logic y_wrap;

	assign x_wrap = (pixel_x == x_last);
	assign y_wrap = (pixel_y == y_last);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pixel_x <= '0;
			pixel_y <= '0;
			h_tick  <= 1'b0;
			v_tick  <= 1'b0;
		end else begin
			// ticks line up with the cycle where the counters read zero
			h_tick <= x_wrap;
			v_tick <= x_wrap && y_wrap;
			if (x_wrap) begin
				pixel_x <= '0;
				pixel_y <= y_wrap ? '0 : pixel_y + 1'b1;
			end else begin
				pixel_x <= pixel_x + 1'b1;
			end
		end
	end

	assign active = (pixel_x >= h_first) && (pixel_x < h_end) &&
		(pixel_y >= v_first) && (pixel_y < v_end);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the tile layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module gfx_tb \
	--Mdir obj_dir -o gfx_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/gfx_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL, see sim.log"
	exit 1
fi

/* sim/gfx_chk.sv */
// arbiter handshake checks only; bound into every mem_arbiter instance
module gfx_chk (
	input logic                CLK,
	input logic                RSTb,
	input logic                rd_valid,
	input mem_pkg::mem_addr_t  rd_addr,
	input logic                rd_ready,
	input logic                mem_we,
	input mem_pkg::arb_owner_t owner
);

	// renderer keeps its address until the data returns
	rd_addr_held: assert property (@(posedge CLK) disable iff (!RSTb)
		(rd_valid && !rd_ready) |=> $stable(rd_addr))
		else $error("rd_addr changed while a renderer read was pending");

	// no read data without a request
	rd_ready_has_valid: assert property (@(posedge CLK) disable iff (!RSTb)
		rd_ready |-> rd_valid)
		else $error("rd_ready pulsed with rd_valid low");

	// writes only ever come from the host side
	no_write_for_renderer: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_we |-> (owner != mem_pkg::arb_renderer))
		else $error("memory write issued during a renderer grant");

endmodule

bind mem_arbiter gfx_chk u_chk (
	.CLK      (CLK),
	.RSTb     (RSTb),
	.rd_valid (rd_valid),
	.rd_addr  (rd_addr),
	.rd_ready (rd_ready),
	.mem_we   (mem_we),
	.owner    (owner)
);

/* sim/gfx_tb.sv */
// directed tests; the memory model only knows the words the tests have written
`include "gfx_defines.svh"

module gfx_tb;

	localparam int frame_cycles = `GFX_LINE_TOTAL * `GFX_FRAME_LINES;
	localparam int test_count = 5;
	localparam int load_words = 1100;
	localparam int timeout_cycles = test_count * 6 * frame_cycles + load_words * 8;

	logic                    CLK;
	logic                    RSTb;
	video_pkg::reg_addr_t    reg_addr;
	logic [15:0]             reg_data;
	logic                    reg_wr;
	logic                    host_valid;
	mem_pkg::mem_addr_t      host_addr;
	mem_pkg::mem_word_t      host_data;
	logic                    host_ready;
	video_pkg::pix_coord_t   out_x;
	video_pkg::pix_coord_t   out_y;
	video_pkg::color_index_t out_color;

	// register copies for the model
	logic        cfg_enable;
	logic [3:0]  cfg_pal;
	logic [15:0] cfg_scroll_x;
	logic [15:0] cfg_scroll_y;
	logic [15:0] cfg_map_base;
	logic [15:0] cfg_tile_base;

	mem_pkg::mem_word_t      mem_model [0:4095];
	video_pkg::color_index_t exp_frame [0:`GFX_ACTIVE_H-1][0:`GFX_ACTIVE_W-1];
	int                      cycle_count = 0;

	gfx_top DUT (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.reg_addr   (reg_addr),
		.reg_data   (reg_data),
		.reg_wr     (reg_wr),
		.host_valid (host_valid),
		.host_addr  (host_addr),
		.host_data  (host_data),
		.host_ready (host_ready),
		.out_x      (out_x),
		.out_y      (out_y),
		.out_color  (out_color)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("run hung: tests did not finish within %0d cycles", timeout_cycles);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic reg_write(input video_pkg::reg_addr_t addr, input logic [15:0] data);
		@(posedge CLK);
		reg_addr <= addr;
		reg_data <= data;
		reg_wr   <= 1'b1;
		@(posedge CLK);
		reg_wr <= 1'b0;
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [15:0] data);
		@(posedge CLK);
		host_valid <= 1'b1;
		host_addr  <= addr;
		host_data  <= data;
		do begin
			@(negedge CLK);
		end while (host_ready !== 1'b1);
		@(posedge CLK);
		host_valid <= 1'b0;
		mem_model[addr[11:0]] = data;
		// ready lasts a single cycle
		@(negedge CLK);
		check_eq("host_ready pulse", 32'd0, 32'(host_ready));
	endtask

	// pixel of the scrolled image at ix, iy from the layout rules
	function automatic logic [3:0] model_pixel(input logic [15:0] ix, input logic [15:0] iy);
		logic [15:0] byte_off;
		logic [15:0] waddr;
		logic [15:0] w;
		logic [7:0]  t;
		byte_off = (iy >> 4) * 16'd128 + (ix >> 4);
		waddr = cfg_map_base + (byte_off >> 1);
		w = mem_model[waddr[11:0]];
		t = byte_off[0] ? w[15:8] : w[7:0];
		if (t == 8'hff) begin
			return 4'd0;
		end
		waddr = cfg_tile_base + {8'd0, t} * 16'd64 + {12'd0, iy[3:0]} * 16'd4 +
			{14'd0, ix[3:2]};
		w = mem_model[waddr[11:0]];
		w = w >> {ix[1:0], 2'b00};
		return w[3:0];
	endfunction

	task automatic wait_frame_start;
		do begin
			@(negedge CLK);
		end while (out_x !== 10'd0 || out_y !== 10'd0);
	endtask

	task automatic score_frame(input string name);
		int ax;
		int ay;
		int ex;
		int ey;
		for (int y = 0; y < `GFX_ACTIVE_H; y++) begin
			for (int x = 0; x < `GFX_ACTIVE_W; x++) begin
				exp_frame[y][x] = cfg_enable ?
					{cfg_pal, model_pixel(cfg_scroll_x + 16'(x), cfg_scroll_y + 16'(y))} : 8'd0;
			end
		end
		// the first frame start may still hold lines from the old setup
		wait_frame_start();
		wait_frame_start();
		for (int i = 0; i < frame_cycles; i++) begin
			if (i > 0) begin
				@(negedge CLK);
			end
			// raster position expected from the line length
			ex = i % `GFX_LINE_TOTAL;
			ey = i / `GFX_LINE_TOTAL;
			check_eq({name, " out_x"}, 32'(ex), 32'(out_x));
			check_eq({name, " out_y"}, 32'(ey), 32'(out_y));
			ax = ex - `GFX_H_START;
			ay = ey - `GFX_V_START;
			if (ax >= 0 && ax < `GFX_ACTIVE_W && ay >= 0 && ay < `GFX_ACTIVE_H) begin
				check_eq(name, 32'(exp_frame[ay][ax]), 32'(out_color));
			end else begin
				check_eq(name, 32'd0, 32'(out_color));
			end
		end
	endtask

	task automatic test_disabled;
		check_eq("reset host_ready", 32'd0, 32'(host_ready));
		score_frame("disabled");
	endtask

	task automatic test_static;
		cfg_map_base  = 16'($urandom % 64);
		cfg_tile_base = 16'h0400 + 16'($urandom % 16'h0800);
		// map rows 0 to 5, columns 0 to 7 cover every scroll below 64
		for (int r = 0; r < 6; r++) begin
			for (int w = 0; w < 4; w++) begin
				mem_write(cfg_map_base + 16'(r * 64 + w),
					{4'd0, 4'($urandom), 4'd0, 4'($urandom)});
			end
		end
		for (int i = 0; i < 1024; i++) begin
			mem_write(cfg_tile_base + 16'(i), 16'($urandom));
		end
		cfg_pal    = 4'($urandom);
		cfg_enable = 1'b1;
		reg_write(`GFX_REG_MAP_BASE, cfg_map_base);
		reg_write(`GFX_REG_TILE_BASE, cfg_tile_base);
		reg_write(`GFX_REG_CTRL, {8'd0, cfg_pal, 3'd0, cfg_enable});
		score_frame("static");
	endtask

	task automatic test_scroll;
		cfg_scroll_x = 16'($urandom % 64);
		cfg_scroll_y = 16'($urandom % 64);
		reg_write(`GFX_REG_SCROLL_X, cfg_scroll_x);
		reg_write(`GFX_REG_SCROLL_Y, cfg_scroll_y);
		score_frame("scroll");
	endtask

	task automatic test_transparent;
		logic [15:0] off;
		logic [15:0] waddr;
		logic [15:0] w;
		for (int k = 0; k < 4; k++) begin
			// a diagonal of visible map entries
			off = ((cfg_scroll_y >> 4) + 16'(k % 2)) * 16'd128 + (cfg_scroll_x >> 4) + 16'(k);
			waddr = cfg_map_base + (off >> 1);
			w = mem_model[waddr[11:0]];
			if (off[0]) begin
				w[15:8] = 8'hff;
			end else begin
				w[7:0] = 8'hff;
			end
			mem_write(waddr, w);
		end
		score_frame("transparent");
	endtask

	task automatic test_host_during_render;
		do begin
			@(negedge CLK);
		end while (out_y !== 10'(`GFX_V_START + 4));
		for (int i = 0; i < 6; i++) begin
			mem_write(cfg_tile_base + 16'($urandom % 1024), 16'($urandom));
		end
		for (int i = 0; i < 2; i++) begin
			mem_write(cfg_map_base + 16'(($urandom % 6) * 64 + ($urandom % 4)),
				{4'd0, 4'($urandom), 4'd0, 4'($urandom)});
		end
		score_frame("host during render");
	endtask

	initial begin
		void'($urandom(32'hfc45));
		RSTb       = 1'b0;
		reg_addr   = '0;
		reg_data   = '0;
		reg_wr     = 1'b0;
		host_valid = 1'b0;
		host_addr  = '0;
		host_data  = '0;
		cfg_enable    = 1'b0;
		cfg_pal       = '0;
		cfg_scroll_x  = '0;
		cfg_scroll_y  = '0;
		cfg_map_base  = '0;
		cfg_tile_base = '0;
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;
		test_disabled();
		test_static();
		test_scroll();
		test_transparent();
		test_host_during_render();
		$display("Finished with no errors");
		$finish;
	end

endmodule
